// File: design/cache_pkg.sv
package cache_pkg;

	// address splits into tag, index, word and byte
	localparam int TAG_W   = 5;
	localparam int INDEX_W = 8;
	localparam int WORD_W  = 2;
	localparam int DATA_W  = 16;
	localparam int ADDR_W  = 16;
	localparam int MEM_AW  = 15;

	// sets per way and words per line
	localparam int SETS  = 2 ** INDEX_W;
	localparam int WORDS = 2 ** WORD_W;

	typedef struct packed {
		logic               en;
		logic               compare;
		logic               write;
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		logic [WORD_W-1:0]  word;
		logic [DATA_W-1:0]  data;
		logic               valid_in;
	} way_req_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] data;
		logic              hit;
		logic              dirty;
		logic              valid;
	} way_rsp_t;

	// read and write are single-cycle pulses
	typedef struct packed {
		logic              read;
		logic              write;
		logic [MEM_AW-1:0] addr;
		logic [DATA_W-1:0] data;
	} mem_req_t;

endpackage

// File: design/cache_way.sv
`timescale 1ns/1ps

module cache_way import cache_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  way_req_t req,
	output way_rsp_t rsp
);

	logic [TAG_W-1:0]  tag_mem  [0:SETS-1];
	logic [DATA_W-1:0] data_mem [0:SETS-1][0:WORDS-1];
	logic [SETS-1:0]   valid;
	logic [SETS-1:0]   dirty;

	logic tag_match;
	logic wr_word;
	logic wr_line;
	logic set_dirty;

	assign tag_match = (tag_mem[req.index] == req.tag);

	// combinational read of the addressed entry
	always_comb begin
		rsp.tag   = tag_mem[req.index];
		rsp.data  = data_mem[req.index][req.word];
		rsp.valid = valid[req.index];
		rsp.dirty = dirty[req.index];
		rsp.hit   = req.en & valid[req.index] & tag_match;
	end

	// compare write only lands on a hit while access write always lands
	assign wr_word   = req.en & req.write & (~req.compare | rsp.hit);
	assign wr_line   = req.en & req.write & ~req.compare;
	assign set_dirty = req.en & req.write & req.compare & rsp.hit;

	always_ff @(posedge clk) begin
		if (wr_word) begin
			data_mem[req.index][req.word] <= req.data;
		end
		if (wr_line) begin
			tag_mem[req.index] <= req.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
			dirty <= '0;
		end else if (wr_line) begin
			// line refill stays clean until written by the requester
			valid[req.index] <= req.valid_in;
			dirty[req.index] <= 1'b0;
		end else if (set_dirty) begin
			dirty[req.index] <= 1'b1;
		end
	end

endmodule

// File: design/cache_controller.sv
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
	input  logic              clk,
	input  logic              rst,

	// requester side
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] data_in,
	input  logic              rd,
	input  logic              wr,
	output logic [DATA_W-1:0] data_out,
	output logic              done,
	output logic              stall,
	output logic              cache_hit,
	output logic              err,

	// ways
	output way_req_t          way0_req,
	output way_req_t          way1_req,
	input  way_rsp_t          way0_rsp,
	input  way_rsp_t          way1_rsp,

	// main memory
	output mem_req_t          mem_req,
	input  logic [DATA_W-1:0] mem_rdata,
	input  logic              mem_stall
);

	typedef enum logic [2:0] {
		idle,
		evict_issue,
		evict_wait,
		fill_issue,
		fill_wait,
		fill_write,
		finish_write
	} state_t;

	state_t state;
	state_t state_nxt;

	logic [WORD_W-1:0]  cnt;
	logic [WORD_W-1:0]  cnt_nxt;
	logic               way_sel;
	logic               way_sel_nxt;
	logic [SETS-1:0]    lru;
	logic               lru_set;
	logic               lru_val;
	logic [DATA_W-1:0]  data_q;
	logic [DATA_W-1:0]  data_nxt;

	logic [TAG_W-1:0]   tag_in;
	logic [INDEX_W-1:0] index_in;
	logic [WORD_W-1:0]  word_in;
	logic               req_any;
	logic               bad;
	logic               req_ok;
	logic               any_hit;
	logic               pick_way;
	logic               pick_dirty;
	way_rsp_t           sel_rsp;

	// per-cycle issue requests resolved after the state decode
	logic               evict_go;
	logic               fill_go;
	logic [WORD_W-1:0]  fill_word;
	way_req_t           base;
	way_req_t           sel_req;

	assign tag_in   = addr[ADDR_W-1 -: TAG_W];
	assign index_in = addr[WORD_W+1 +: INDEX_W];
	assign word_in  = addr[1 +: WORD_W];

	assign req_any = rd | wr;
	assign bad     = addr[0] | (rd & wr);
	assign req_ok  = req_any & ~bad;
	assign any_hit = way0_rsp.hit | way1_rsp.hit;

	// invalid way first, way 0 before way 1, then lru
	assign pick_way   = ~way0_rsp.valid ? 1'b0 :
	                    ~way1_rsp.valid ? 1'b1 : lru[index_in];
	assign pick_dirty = pick_way ? (way1_rsp.valid & way1_rsp.dirty) :
	                               (way0_rsp.valid & way0_rsp.dirty);

	assign sel_rsp = way_sel ? way1_rsp : way0_rsp;

	assign stall    = (state != idle) | req_any;
	assign data_out = data_nxt;

	always_comb begin
		base          = '0;
		base.tag      = tag_in;
		base.index    = index_in;
		base.word     = word_in;
		base.data     = data_in;
		sel_req       = base;
		way0_req      = base;
		way1_req      = base;
		mem_req       = '0;
		state_nxt     = state;
		cnt_nxt       = cnt;
		way_sel_nxt   = way_sel;
		lru_set       = 1'b0;
		lru_val       = 1'b0;
		data_nxt      = data_q;
		done          = 1'b0;
		err           = 1'b0;
		cache_hit     = 1'b0;
		evict_go      = 1'b0;
		fill_go       = 1'b0;
		fill_word     = cnt;

		case (state)
			idle: begin
				cnt_nxt          = '0;
				way0_req.en      = req_ok;
				way0_req.compare = 1'b1;
				way0_req.write   = wr;
				way1_req.en      = req_ok;
				way1_req.compare = 1'b1;
				way1_req.write   = wr;
				if (req_any && bad) begin
					done = 1'b1;
					err  = 1'b1;
				end else if (req_ok && any_hit) begin
					done      = 1'b1;
					cache_hit = 1'b1;
					// other way becomes the victim
					lru_set   = 1'b1;
					lru_val   = way0_rsp.hit;
					if (rd) begin
						data_nxt = way0_rsp.hit ? way0_rsp.data : way1_rsp.data;
					end
				end else if (req_ok) begin
					way_sel_nxt = pick_way;
					state_nxt   = pick_dirty ? evict_issue : fill_issue;
				end
			end
			evict_issue: begin
				evict_go  = 1'b1;
				state_nxt = evict_wait;
			end
			evict_wait: begin
				// next word goes out in the first cycle the stall is gone
				if (!mem_stall) begin
					if (cnt != '0) begin
						evict_go = 1'b1;
					end else begin
						fill_go   = 1'b1;
						fill_word = '0;
						state_nxt = fill_wait;
					end
				end
			end
			fill_issue: begin
				fill_go   = 1'b1;
				state_nxt = fill_wait;
			end
			fill_wait: begin
				if (!mem_stall) begin
					state_nxt = fill_write;
				end
			end
			fill_write: begin
				sel_req.en       = 1'b1;
				sel_req.write    = 1'b1;
				sel_req.word     = cnt;
				sel_req.data     = mem_rdata;
				sel_req.valid_in = (cnt == WORD_W'(WORDS - 1));
				if (rd && cnt == word_in) begin
					data_nxt = mem_rdata;
				end
				if (cnt == WORD_W'(WORDS - 1)) begin
					lru_set = 1'b1;
					lru_val = ~way_sel;
					cnt_nxt = '0;
					if (wr) begin
						state_nxt = finish_write;
					end else begin
						done      = 1'b1;
						state_nxt = idle;
					end
				end else begin
					// overlap the next fetch with this line write
					fill_go   = 1'b1;
					fill_word = cnt + 1'b1;
					cnt_nxt   = cnt + 1'b1;
					state_nxt = fill_wait;
				end
			end
			finish_write: begin
				sel_req.en      = 1'b1;
				sel_req.compare = 1'b1;
				sel_req.write   = 1'b1;
				done            = 1'b1;
				state_nxt       = idle;
			end
			default: begin
				state_nxt = idle;
			end
		endcase

		// victim word read out of the chosen way straight into memory
		if (evict_go) begin
			sel_req.en    = 1'b1;
			sel_req.word  = cnt;
			mem_req.write = 1'b1;
			mem_req.addr  = {sel_rsp.tag, index_in, cnt};
			mem_req.data  = sel_rsp.data;
			cnt_nxt       = cnt + 1'b1;
		end

		if (fill_go) begin
			mem_req.read = 1'b1;
			mem_req.addr = {tag_in, index_in, fill_word};
		end

		if (state != idle) begin
			if (way_sel) begin
				way1_req = sel_req;
			end else begin
				way0_req = sel_req;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= idle;
			cnt     <= '0;
			way_sel <= 1'b0;
			lru     <= '0;
		end else begin
			state   <= state_nxt;
			cnt     <= cnt_nxt;
			way_sel <= way_sel_nxt;
			if (lru_set) begin
				lru[index_in] <= lru_val;
			end
		end
	end

	// holds the last read word for the requester
	always_ff @(posedge clk) begin
		data_q <= data_nxt;
	end

endmodule

// File: design/main_memory.sv
`timescale 1ns/1ps

module main_memory import cache_pkg::*; #(
	parameter int MEM_LATENCY = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  mem_req_t          req,
	output logic [DATA_W-1:0] rdata,
	output logic              stall
);

	localparam int DEPTH = 2 ** MEM_AW;
	localparam int CNT_W = $clog2(MEM_LATENCY + 1) + 1;

	logic [DATA_W-1:0] mem [0:DEPTH-1];
	logic [CNT_W-1:0]  lat_cnt;

	// preloaded contents are word address xor 5a5a
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = DATA_W'(i) ^ 16'h5a5a;
		end
	end

	// write lands at the pulse and the read word is held until the next read
	always @(posedge clk) begin
		if (req.write) begin
			mem[req.addr] <= req.data;
		end
		if (req.read) begin
			rdata <= mem[req.addr];
		end
	end

	// stall window starts the cycle after the pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			lat_cnt <= '0;
		end else if (req.read || req.write) begin
			lat_cnt <= CNT_W'(MEM_LATENCY);
		end else if (lat_cnt != '0) begin
			lat_cnt <= lat_cnt - 1'b1;
		end
	end

	assign stall = (lat_cnt != '0);

endmodule

// File: design/cache_system.sv
`timescale 1ns/1ps

module cache_system import cache_pkg::*; #(
	parameter int MEM_LATENCY = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] data_in,
	input  logic              rd,
	input  logic              wr,
	output logic [DATA_W-1:0] data_out,
	output logic              done,
	output logic              stall,
	output logic              cache_hit,
	output logic              err
);

	way_req_t          way0_req;
	way_req_t          way1_req;
	way_rsp_t          way0_rsp;
	way_rsp_t          way1_rsp;
	mem_req_t          mem_req;
	logic [DATA_W-1:0] mem_rdata;
	logic              mem_stall;

	cache_controller u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err),
		.way0_req  (way0_req),
		.way1_req  (way1_req),
		.way0_rsp  (way0_rsp),
		.way1_rsp  (way1_rsp),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.mem_stall (mem_stall)
	);

	cache_way u_way0 (
		.clk (clk),
		.rst (rst),
		.req (way0_req),
		.rsp (way0_rsp)
	);

	cache_way u_way1 (
		.clk (clk),
		.rst (rst),
		.req (way1_req),
		.rsp (way1_rsp)
	);

	main_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk   (clk),
		.rst   (rst),
		.req   (mem_req),
		.rdata (mem_rdata),
		.stall (mem_stall)
	);

endmodule

// File: testbench/tb_cache_system.sv
`timescale 1ns/1ps

module tb_cache_system import cache_pkg::*; ();

	localparam int MEM_LATENCY = 3;
	localparam int N_RAND      = 60;
	localparam int MAX_TABLE   = 32;
	localparam logic [1:0] OP_RD  = 2'd0;
	localparam logic [1:0] OP_WR  = 2'd1;
	localparam logic [1:0] OP_BAD = 2'd2;

	typedef struct packed {
		logic [1:0]        op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              hit;
		logic [DATA_W-1:0] rdata;
	} entry_t;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data_in;
	logic              rd;
	logic              wr;
	logic [DATA_W-1:0] data_out;
	logic              done;
	logic              stall;
	logic              cache_hit;
	logic              err;

	entry_t tbl [0:MAX_TABLE-1];
	string  names [0:MAX_TABLE-1];
	int     table_n = 0;
	int     checks = 0;
	int     errors = 0;

	// requester view of memory plus per-set tag state
	logic [DATA_W-1:0] sh_mem [0:2**MEM_AW-1];
	logic [TAG_W-1:0]  sh_tag [0:SETS-1][0:1];
	logic              sh_valid [0:SETS-1][0:1];
	logic              sh_dirty [0:SETS-1][0:1];
	logic              sh_lru [0:SETS-1];

	cache_system #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic add_entry(input string name, input logic [1:0] op, input logic [15:0] a,
		input logic [15:0] d, input logic hit, input logic [15:0] rdata);
		names[table_n] = name;
		tbl[table_n]   = '{op, a, d, hit, rdata};
		table_n++;
	endtask

	// hit and victim choice for an address without touching state
	function automatic void lookup(input logic [15:0] a, output logic hit,
		output logic way, output logic vdirty);
		logic [TAG_W-1:0]   tg;
		logic [INDEX_W-1:0] ix;
		tg     = a[15:11];
		ix     = a[10:3];
		hit    = 1'b0;
		way    = 1'b0;
		vdirty = 1'b0;
		if (sh_valid[ix][0] && sh_tag[ix][0] == tg) begin
			hit = 1'b1;
		end else if (sh_valid[ix][1] && sh_tag[ix][1] == tg) begin
			hit = 1'b1;
			way = 1'b1;
		end else begin
			way    = !sh_valid[ix][0] ? 1'b0 : !sh_valid[ix][1] ? 1'b1 : sh_lru[ix];
			vdirty = sh_valid[ix][way] & sh_dirty[ix][way];
		end
	endfunction

	task automatic apply_request(input string name, input logic [1:0] op, input logic [15:0] a,
		input logic [15:0] d, input logic exp_hit, input logic [15:0] exp_data);
		logic               bad;
		logic               s_hit;
		logic               way;
		logic               vdirty;
		logic [INDEX_W-1:0] ix;
		int                 exp_lat;
		int                 lat;
		bad     = (op == OP_BAD) | a[0];
		ix      = a[10:3];
		exp_lat = 0;
		if (!bad) begin
			lookup(a, s_hit, way, vdirty);
			if (!s_hit) begin
				exp_lat = 1 + 4 * (MEM_LATENCY + 2) + (op == OP_WR ? 1 : 0);
				if (vdirty) begin
					exp_lat += 4 * (MEM_LATENCY + 1);
				end
				sh_tag[ix][way]   = a[15:11];
				sh_valid[ix][way] = 1'b1;
				sh_dirty[ix][way] = 1'b0;
			end
			sh_lru[ix] = ~way;
			if (op == OP_WR) begin
				sh_dirty[ix][way] = 1'b1;
				sh_mem[a[15:1]]   = d;
			end
		end
		@(negedge clk);
		addr    = a;
		data_in = d;
		rd      = (op != OP_WR);
		wr      = (op != OP_RD);
		#1;
		lat = 0;
		check({name, ".stall"}, 1'b1, stall);
		while (!done) begin
			@(negedge clk);
			#1;
			lat++;
			check({name, ".stall"}, 1'b1, stall);
		end
		check({name, ".err"}, bad, err);
		check({name, ".hit"}, exp_hit & ~bad, cache_hit);
		check({name, ".latency"}, exp_lat, lat);
		if (op == OP_RD && !bad) begin
			check({name, ".data"}, exp_data, data_out);
		end
	endtask

	// hang guard sized for the worst case of every request
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < (table_n + N_RAND) * (1 + 8 * (MEM_LATENCY + 2)) + 100) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no done from the DUT after %0d cycles", cycles);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [15:0] a;
		logic [15:0] d;
		logic [1:0]  op;
		logic        hit;
		logic        way;
		logic        vdirty;
		int          r;
		rst     = 1'b1;
		addr    = '0;
		data_in = '0;
		rd      = 1'b0;
		wr      = 1'b0;
		void'($urandom(32'hbd65_b880));
		for (int i = 0; i < 2**MEM_AW; i++) begin
			sh_mem[i] = DATA_W'(i) ^ 16'h5a5a;
		end
		for (int s = 0; s < SETS; s++) begin
			sh_valid[s][0] = 1'b0;
			sh_valid[s][1] = 1'b0;
			sh_dirty[s][0] = 1'b0;
			sh_dirty[s][1] = 1'b0;
			sh_lru[s]      = 1'b0;
		end

		// set 5 holds tags 0, 1 and 2 and set 8 takes the write miss
		add_entry("cold_rd",          OP_RD,  16'h0028, 16'h0000, 1'b0, 16'h5a4e);
		add_entry("rd_hit_w2",        OP_RD,  16'h002c, 16'h0000, 1'b1, 16'h5a4c);
		add_entry("wr_hit",           OP_WR,  16'h002a, 16'hbeef, 1'b1, 16'h0000);
		add_entry("rd_after_wr",      OP_RD,  16'h002a, 16'h0000, 1'b1, 16'hbeef);
		add_entry("rd_neighbor",      OP_RD,  16'h002e, 16'h0000, 1'b1, 16'h5a4d);
		add_entry("tag1_miss",        OP_RD,  16'h0828, 16'h0000, 1'b0, 16'h5e4e);
		add_entry("tag0_hit",         OP_RD,  16'h0028, 16'h0000, 1'b1, 16'h5a4e);
		add_entry("tag2_evict",       OP_RD,  16'h1028, 16'h0000, 1'b0, 16'h524e);
		add_entry("tag0_kept",        OP_RD,  16'h0028, 16'h0000, 1'b1, 16'h5a4e);
		add_entry("tag1_reread",      OP_RD,  16'h0828, 16'h0000, 1'b0, 16'h5e4e);
		add_entry("tag2_dirty_evict", OP_RD,  16'h1028, 16'h0000, 1'b0, 16'h524e);
		add_entry("tag0_refetch",     OP_RD,  16'h002a, 16'h0000, 1'b0, 16'hbeef);
		add_entry("bad_odd",          OP_RD,  16'h002b, 16'h0000, 1'b0, 16'h0000);
		add_entry("bad_both",         OP_BAD, 16'h002a, 16'h1111, 1'b0, 16'h0000);
		add_entry("wr_miss",          OP_WR,  16'h3040, 16'h1234, 1'b0, 16'h0000);
		add_entry("rd_wr_miss",       OP_RD,  16'h3040, 16'h0000, 1'b1, 16'h1234);
		add_entry("rd_line_rest",     OP_RD,  16'h3046, 16'h0000, 1'b1, 16'h4279);
		add_entry("after_err_hit",    OP_RD,  16'h002a, 16'h0000, 1'b1, 16'hbeef);

		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		#1;
		check("reset.done", 1'b0, done);
		check("reset.err", 1'b0, err);
		check("reset.hit", 1'b0, cache_hit);
		check("reset.stall", 1'b0, stall);

		for (int i = 0; i < table_n; i++) begin
			apply_request(names[i], tbl[i].op, tbl[i].addr, tbl[i].data,
				tbl[i].hit, tbl[i].rdata);
		end

		// 3 tags over sets 5..8 to force conflicts
		for (int i = 0; i < N_RAND; i++) begin
			r  = $urandom % 10;
			a  = {5'($urandom % 3), 8'(5 + $urandom % 4), 2'($urandom % 4), 1'b0};
			d  = 16'($urandom);
			op = (r == 0) ? OP_BAD : (r < 5) ? OP_WR : OP_RD;
			if (r == 1) begin
				a[0] = 1'b1;
			end
			lookup(a, hit, way, vdirty);
			apply_request($sformatf("rand_%0d", i), op, a, d, hit, sh_mem[a[15:1]]);
		end

		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
		#1;
		check("idle.stall", 1'b0, stall);
		check("idle.done", 1'b0, done);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: sim.f
design/cache_pkg.sv
design/cache_way.sv
design/cache_controller.sv
design/main_memory.sv
design/cache_system.sv
testbench/tb_cache_system.sv
